// File: Makefile
# Verilator build, run and lint for the axis_uart testbench

VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := axis_uart_tb
FILELIST  := axis_uart.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: all lint clean

all: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: axis_uart.f
source/uart_line_pkg.sv
source/uart_stream_pkg.sv
source/uart_rx.sv
source/uart_rx_buffer.sv
source/uart_tx.sv
source/axis_uart.sv
verif/axis_uart_props.sv
verif/axis_uart_tb.sv

// File: source/axis_uart.sv
// UART peripheral with byte-stream ports
// Receiver feeding a credit-controlled receive buffer, with an
// independent transmitter alongside

`timescale 1ns/1ns
`default_nettype none

module axis_uart #(
    parameter int RX_DEPTH   = 4,
    parameter int RX_CREDITS = 2
) (
    input  logic                        m_axis,
    input  logic                        arst_n_i,
    input  logic                        uart_rx_i,
    output logic                        uart_tx_o,
    input  uart_line_pkg::parity_mode_e parity_i,
    input  uart_line_pkg::clk_div_t     clk_div_i,
    output uart_stream_pkg::byte_beat_t rx_beat_o,
    input  logic                        rx_credit_i,
    input  uart_stream_pkg::byte_beat_t tx_beat_i,
    output logic                        tx_credit_o,
    output logic                        rx_parity_err_o,
    output logic                        rx_overflow_o
);

    uart_stream_pkg::byte_beat_t rx_beat;  // Receiver to buffer

    uart_rx u_rx (
        .m_axis       (m_axis),
        .arst_n_i     (arst_n_i),
        .parity_i     (parity_i),
        .clk_div_i    (clk_div_i),
        .uart_rx_i    (uart_rx_i),
        .beat_o       (rx_beat),
        .parity_err_o (rx_parity_err_o)
    );

    uart_rx_buffer #(
        .RX_DEPTH   (RX_DEPTH),
        .RX_CREDITS (RX_CREDITS)
    ) u_rx_buffer (
        .m_axis     (m_axis),
        .arst_n_i   (arst_n_i),
        .beat_i     (rx_beat),
        .credit_i   (rx_credit_i),
        .beat_o     (rx_beat_o),
        .overflow_o (rx_overflow_o)
    );

    uart_tx u_tx (
        .m_axis    (m_axis),
        .arst_n_i  (arst_n_i),
        .parity_i  (parity_i),
        .clk_div_i (clk_div_i),
        .beat_i    (tx_beat_i),
        .uart_tx_o (uart_tx_o),
        .credit_o  (tx_credit_o)
    );

endmodule

`default_nettype wire

// File: source/uart_line_pkg.sv
// UART line-side types
// Serial byte, parity setting, bit-period divider and the state
// encodings of the receive and transmit machines

`default_nettype none

package uart_line_pkg;

    typedef logic [7:0]  uart_data_t;  // One serial data byte
    typedef logic [15:0] clk_div_t;    // Clock cycles per serial bit

    typedef enum logic [1:0] {
        parity_none = 2'd0,
        parity_even = 2'd1,
        parity_odd  = 2'd2
    } parity_mode_e;

    typedef enum logic [2:0] {
        rx_idle, rx_start, rx_data, rx_parity, rx_stop, rx_done
    } rx_state_e;

    typedef enum logic [2:0] {
        tx_idle, tx_start, tx_data, tx_parity, tx_stop
    } tx_state_e;

endpackage

`default_nettype wire

// File: source/uart_rx.sv
// UART receiver
// Synchronizes the serial line, validates the start bit at mid-bit,
// shifts in 8 data bits LSB first and checks optional parity.
// A good frame leaves as a one-cycle beat from the done state,
// a frame with bad parity is dropped and flagged instead

`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic                         m_axis,
    input  logic                         arst_n_i,
    input  uart_line_pkg::parity_mode_e  parity_i,
    input  uart_line_pkg::clk_div_t      clk_div_i,
    input  logic                         uart_rx_i,
    output uart_stream_pkg::byte_beat_t  beat_o,
    output logic                         parity_err_o
);

    uart_line_pkg::rx_state_e state_q;
    uart_line_pkg::clk_div_t  baud_cnt;
    uart_line_pkg::uart_data_t shift_q;

    logic [1:0] sync_q;
    logic [2:0] bit_cnt;
    logic       rx_line;
    logic       par_err_q;
    logic       baud_done;
    logic       mid_start;
    logic       parity_on;
    logic       exp_par;

    assign rx_line   = sync_q[1];
    assign baud_done = (baud_cnt == clk_div_i - 16'd1);
    assign mid_start = (state_q == uart_line_pkg::rx_start) &&
                       (baud_cnt == (clk_div_i >> 1) - 16'd1);
    assign parity_on = (parity_i == uart_line_pkg::parity_even) ||
                       (parity_i == uart_line_pkg::parity_odd);
    assign exp_par   = (parity_i == uart_line_pkg::parity_odd) ? ~^shift_q : ^shift_q;

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge m_axis or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], uart_rx_i};
        end
    end

    always_ff @(posedge m_axis or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= uart_line_pkg::rx_idle;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            par_err_q <= 1'b0;
        end else begin
            case (state_q)
                uart_line_pkg::rx_idle: begin
                    baud_cnt  <= '0;
                    bit_cnt   <= '0;
                    par_err_q <= 1'b0;
                    if (!rx_line) begin
                        state_q <= uart_line_pkg::rx_start;  // Falling edge seen
                    end
                end
                uart_line_pkg::rx_start: begin
                    if (mid_start) begin
                        baud_cnt <= '0;
                        // Line back high at mid-bit means a glitch
                        state_q  <= rx_line ? uart_line_pkg::rx_idle : uart_line_pkg::rx_data;
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
                uart_line_pkg::rx_data: begin
                    if (baud_done) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state_q <= parity_on ? uart_line_pkg::rx_parity
                                                 : uart_line_pkg::rx_stop;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
                uart_line_pkg::rx_parity: begin
                    if (baud_done) begin
                        baud_cnt  <= '0;
                        par_err_q <= (rx_line != exp_par);
                        state_q   <= uart_line_pkg::rx_stop;
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
                uart_line_pkg::rx_stop: begin
                    if (baud_done) begin
                        baud_cnt <= '0;
                        state_q  <= uart_line_pkg::rx_done;  // Stop level not checked
                    end else begin
                        baud_cnt <= baud_cnt + 16'd1;
                    end
                end
                uart_line_pkg::rx_done: begin
                    state_q <= uart_line_pkg::rx_idle;
                end
                default: begin
                    state_q <= uart_line_pkg::rx_idle;
                end
            endcase
        end
    end

    // Sampling points fall at mid-bit since the start check realigned the counter
    always_ff @(posedge m_axis) begin
        if ((state_q == uart_line_pkg::rx_data) && baud_done) begin
            shift_q <= {rx_line, shift_q[7:1]};  // LSB arrives first
        end
    end

    assign beat_o = '{valid: (state_q == uart_line_pkg::rx_done) && !par_err_q,
                      data:  shift_q};

    assign parity_err_o = (state_q == uart_line_pkg::rx_done) && par_err_q;

endmodule

`default_nettype wire

// File: source/uart_rx_buffer.sv
// UART receive buffer
// Circular store for good bytes, drained in arrival order while the
// downstream side has granted credits. A byte arriving while the store
// is full is discarded and reported in the same cycle

`timescale 1ns/1ns
`default_nettype none

module uart_rx_buffer #(
    parameter int RX_DEPTH   = 4,
    parameter int RX_CREDITS = 2
) (
    input  logic                        m_axis,
    input  logic                        arst_n_i,
    input  uart_stream_pkg::byte_beat_t beat_i,
    input  logic                        credit_i,
    output uart_stream_pkg::byte_beat_t beat_o,
    output logic                        overflow_o
);

    localparam int PTR_W = $clog2(RX_DEPTH);
    localparam int CNT_W = $clog2(RX_DEPTH + 1);

    uart_line_pkg::uart_data_t   mem [RX_DEPTH];
    uart_stream_pkg::credit_cnt_t credits;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             full;
    logic             push;
    logic             pop;

    assign full       = (fill == CNT_W'(RX_DEPTH));
    assign push       = beat_i.valid && !full;
    assign pop        = (fill != '0) && (credits != '0);  // Send only with a credit in hand
    assign overflow_o = beat_i.valid && full;

    assign beat_o = '{valid: pop, data: mem[rd_ptr]};

    always_ff @(posedge m_axis) begin
        if (push) begin
            mem[wr_ptr] <= beat_i.data;
        end
    end

    always_ff @(posedge m_axis or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            credits <= uart_stream_pkg::credit_cnt_t'(RX_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            case ({credit_i, pop})
                2'b10:   credits <= credits + 4'd1;  // Slot freed downstream
                2'b01:   credits <= credits - 4'd1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/uart_stream_pkg.sv
// UART stream-side types
// One byte transfer on the credit-controlled stream ports and the
// counter type used to track credits

`default_nettype none

package uart_stream_pkg;

    // Single-cycle transfer, valid only while the sender holds a credit
    typedef struct packed {
        logic                    valid;
        uart_line_pkg::uart_data_t data;
    } byte_beat_t;

    typedef logic [3:0] credit_cnt_t;  // Up to 15 credits

endpackage

`default_nettype wire

// File: source/uart_tx.sv
// UART transmitter
// Takes one byte beat into a holding register and serializes it as
// start bit, 8 data bits LSB first, optional parity and stop bit.
// The single credit is handed back one cycle after the stop bit ends

`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic                        m_axis,
    input  logic                        arst_n_i,
    input  uart_line_pkg::parity_mode_e parity_i,
    input  uart_line_pkg::clk_div_t     clk_div_i,
    input  uart_stream_pkg::byte_beat_t beat_i,
    output logic                        uart_tx_o,
    output logic                        credit_o
);

    uart_line_pkg::tx_state_e  state_q;
    uart_line_pkg::clk_div_t   baud_cnt;
    uart_line_pkg::uart_data_t hold_q;

    logic [2:0] bit_cnt;
    logic       par_q;
    logic       baud_done;
    logic       parity_on;
    logic       accept;

    assign baud_done = (baud_cnt == clk_div_i - 16'd1);
    assign parity_on = (parity_i == uart_line_pkg::parity_even) ||
                       (parity_i == uart_line_pkg::parity_odd);
    assign accept    = (state_q == uart_line_pkg::tx_idle) && beat_i.valid;

    always_ff @(posedge m_axis or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= uart_line_pkg::tx_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            credit_o <= 1'b0;
        end else begin
            credit_o <= 1'b0;
            if (state_q == uart_line_pkg::tx_idle) begin
                baud_cnt <= '0;
                bit_cnt  <= '0;
                if (accept) begin
                    state_q <= uart_line_pkg::tx_start;
                end
            end else if (!baud_done) begin
                baud_cnt <= baud_cnt + 16'd1;
            end else begin
                baud_cnt <= '0;
                case (state_q)
                    uart_line_pkg::tx_start: begin
                        state_q <= uart_line_pkg::tx_data;
                    end
                    uart_line_pkg::tx_data: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state_q <= parity_on ? uart_line_pkg::tx_parity
                                                 : uart_line_pkg::tx_stop;
                        end
                    end
                    uart_line_pkg::tx_parity: begin
                        state_q <= uart_line_pkg::tx_stop;
                    end
                    uart_line_pkg::tx_stop: begin
                        state_q  <= uart_line_pkg::tx_idle;
                        credit_o <= 1'b1;  // Holding slot free again
                    end
                    default: begin
                        state_q <= uart_line_pkg::tx_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge m_axis) begin
        if (accept) begin
            hold_q <= beat_i.data;
            par_q  <= (parity_i == uart_line_pkg::parity_odd) ? ~^beat_i.data : ^beat_i.data;
        end else if ((state_q == uart_line_pkg::tx_data) && baud_done) begin
            hold_q <= hold_q >> 1;  // Next bit to position 0
        end
    end

    always_comb begin
        case (state_q)
            uart_line_pkg::tx_start:  uart_tx_o = 1'b0;
            uart_line_pkg::tx_data:   uart_tx_o = hold_q[0];
            uart_line_pkg::tx_parity: uart_tx_o = par_q;
            default:                  uart_tx_o = 1'b1;  // Idle and stop are high
        endcase
    end

endmodule

`default_nettype wire

// File: verif/axis_uart_props.sv
// Bound checks for the UART peripheral
// Rx stream credit rule, transmit line level after reset and
// transmit credit return

`timescale 1ns/1ns
`default_nettype none

module axis_uart_props #(
    parameter int RX_CREDITS = 2
) (
    input logic                        m_axis,
    input logic                        arst_n_i,
    input logic                        uart_tx_i,
    input logic                        tx_credit_i,
    input uart_stream_pkg::byte_beat_t tx_beat_i,
    input uart_stream_pkg::byte_beat_t rx_beat_i,
    input logic                        rx_credit_i
);

    int   rx_credits;  // Credits the buffer should hold, from stream traffic
    logic tx_pending;  // Tx beat sent, its credit not back yet

    always_ff @(posedge m_axis or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_credits <= RX_CREDITS;
            tx_pending <= 1'b0;
        end else begin
            rx_credits <= rx_credits + int'(rx_credit_i) - int'(rx_beat_i.valid);
            if (tx_beat_i.valid) begin
                tx_pending <= 1'b1;
            end else if (tx_credit_i) begin
                tx_pending <= 1'b0;
            end
        end
    end

    a_beat_has_credit: assert property (@(posedge m_axis) disable iff (!arst_n_i)
        rx_beat_i.valid |-> (rx_credits > 0))
        else $error("rx beat sent while the buffer held no credit");

    a_line_high_after_reset: assert property (@(posedge m_axis)
        $rose(arst_n_i) |-> uart_tx_i)
        else $error("serial tx line not idle high after reset");

    // A credit only comes back for a beat still in flight
    a_credit_after_beat: assert property (@(posedge m_axis) disable iff (!arst_n_i)
        tx_credit_i |-> tx_pending)
        else $error("tx credit returned while the transmitter was idle");

endmodule

bind axis_uart axis_uart_props #(.RX_CREDITS(RX_CREDITS)) u_props (
    .m_axis      (m_axis),
    .arst_n_i    (arst_n_i),
    .uart_tx_i   (uart_tx_o),
    .tx_credit_i (tx_credit_o),
    .tx_beat_i   (tx_beat_i),
    .rx_beat_i   (rx_beat_o),
    .rx_credit_i (rx_credit_i)
);

`default_nettype wire

// File: verif/axis_uart_stim.txt
// One item per word: mode, parity, divider (4 digits), byte (2 digits), outcome
// Modes 0 loop 1 good 2 bad parity 3 glitch 4 credits held 5 drain F end
000008A51
0100083C1
0200087E1
000005011
010005FF1
020005801
210006C32
110006961
300008000
1000084D1
400006111
400006221
400006333
400006443
400006553
400006663
400006774
500006331
500006441
500006551
500006661
000010E71
F00000000

// File: verif/axis_uart_tb.sv
// Testbench for the UART peripheral
// Reads test items from the stimulus file, runs loopback and directly
// driven frames, and checks rx beats, credits and status pulses

`timescale 1ns/1ns
`default_nettype none

module axis_uart_tb;

    localparam int MAX_ITEMS = 64;
    localparam logic [3:0] M_LOOP   = 4'h0;
    localparam logic [3:0] M_GOOD   = 4'h1;
    localparam logic [3:0] M_BADPAR = 4'h2;
    localparam logic [3:0] M_GLITCH = 4'h3;
    localparam logic [3:0] M_HOLD   = 4'h4;
    localparam logic [3:0] M_DRAIN  = 4'h5;
    localparam logic [3:0] M_END    = 4'hF;
    localparam logic [3:0] E_BEAT   = 4'h1;
    localparam logic [3:0] E_PERR   = 4'h2;
    localparam logic [3:0] E_OVF    = 4'h4;
    localparam int SEL_BEAT = 0;
    localparam int SEL_PERR = 1;
    localparam int SEL_OVF  = 2;
    localparam int SEL_TXC  = 3;

    logic                        m_axis;
    logic                        arst_n_i;
    logic                        loop_sel;
    logic                        drv_line;
    logic                        rx_line;
    logic                        tx_line;
    logic                        rx_credit;
    logic                        tx_credit;
    logic                        rx_perr;
    logic                        rx_ovf;
    uart_line_pkg::parity_mode_e parity;
    uart_line_pkg::clk_div_t     clk_div;
    uart_stream_pkg::byte_beat_t rx_beat;
    uart_stream_pkg::byte_beat_t tx_beat;

    logic [35:0] stim_mem [MAX_ITEMS];
    logic [7:0]  rx_q [$];
    int perr_cnt = 0;
    int ovf_cnt = 0;
    int txc_cnt = 0;
    int tx_sent = 0;
    int exp_perr = 0;
    int exp_ovf = 0;
    int owed = 0;        // Rx beats consumed with credit not yet returned
    int tx_credits = 1;

    always #2 m_axis = ~m_axis;

    assign rx_line = loop_sel ? tx_line : drv_line;

    axis_uart #(.RX_DEPTH(4), .RX_CREDITS(2)) uut (
        .m_axis          (m_axis),
        .arst_n_i        (arst_n_i),
        .uart_rx_i       (rx_line),
        .uart_tx_o       (tx_line),
        .parity_i        (parity),
        .clk_div_i       (clk_div),
        .rx_beat_o       (rx_beat),
        .rx_credit_i     (rx_credit),
        .tx_beat_i       (tx_beat),
        .tx_credit_o     (tx_credit),
        .rx_parity_err_o (rx_perr),
        .rx_overflow_o   (rx_ovf)
    );

    // Mid-cycle sampling, outputs are settled here
    always @(negedge m_axis) begin
        if (rx_beat.valid === 1'b1) rx_q.push_back(rx_beat.data);
        if (rx_perr === 1'b1) perr_cnt++;
        if (rx_ovf === 1'b1) ovf_cnt++;
        if (tx_credit === 1'b1) txc_cnt++;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, act, exp));
        end
    endtask

    function automatic int event_count(input int sel);
        case (sel)
            SEL_BEAT: return rx_q.size();
            SEL_PERR: return perr_cnt;
            SEL_OVF:  return ovf_cnt;
            default:  return txc_cnt;
        endcase
    endfunction

    task automatic wait_for(input string what, input int sel, input int target, input int limit);
        int n;
        n = 0;
        while (event_count(sel) < target && n < limit) begin
            @(posedge m_axis);
            n++;
        end
        if (event_count(sel) < target) begin
            fail_run($sformatf("timeout waiting for %s after %0d cycles", what, limit));
        end
    endtask

    task automatic return_owed();
        while (owed > 0) begin
            repeat ($urandom % 4) @(posedge m_axis);  // Random gap before each return
            rx_credit <= 1'b1;
            @(posedge m_axis);
            rx_credit <= 1'b0;
            owed--;
        end
    endtask

    task automatic send_tx(input logic [7:0] b, input int limit);
        if (tx_credits == 0) fail_run("transmit beat attempted without a credit");
        tx_credits--;
        tx_beat.valid <= 1'b1;
        tx_beat.data  <= b;
        @(posedge m_axis);
        tx_beat.valid <= 1'b0;
        tx_sent++;
        wait_for("transmit credit", SEL_TXC, tx_sent, limit);
        tx_credits++;
    endtask

    task automatic drive_bit(input logic v, input int d);
        drv_line <= v;
        repeat (d) @(posedge m_axis);
    endtask

    task automatic drive_frame(input logic [7:0] b, input uart_line_pkg::parity_mode_e par,
                               input int d, input logic bad);
        drive_bit(1'b0, d);
        for (int i = 0; i < 8; i++) drive_bit(b[i], d);  // LSB first
        if (par != uart_line_pkg::parity_none) begin
            drive_bit(^b ^ (par == uart_line_pkg::parity_odd) ^ bad, d);
        end
        drive_bit(1'b1, d);
    endtask

    task automatic run_item(input logic [35:0] item);
        logic [3:0]                  mode;
        logic [3:0]                  outcome;
        logic [7:0]                  b;
        uart_line_pkg::parity_mode_e par;
        int                          d;
        int                          limit;
        mode    = item[35:32];
        par     = uart_line_pkg::parity_mode_e'(item[29:28]);
        d       = int'(item[27:12]);
        b       = item[11:4];
        outcome = item[3:0];
        limit   = 12 * d + 40;
        if (mode < M_HOLD) return_owed();
        parity   <= par;  // Both directions idle here
        clk_div  <= uart_line_pkg::clk_div_t'(d);
        loop_sel <= (mode == M_LOOP);
        repeat (2) @(posedge m_axis);
        case (mode)
            M_LOOP:         send_tx(b, limit);
            M_GOOD, M_HOLD: drive_frame(b, par, d, 1'b0);
            M_BADPAR:       drive_frame(b, par, d, 1'b1);
            M_GLITCH: begin
                drv_line <= 1'b0;
                repeat (d / 2 - 1) @(posedge m_axis);  // Shorter than half a bit
                drv_line <= 1'b1;
                repeat (2 * d) @(posedge m_axis);
            end
            M_DRAIN: begin
                if (owed == 0) fail_run("drain item found no withheld credit");
                rx_credit <= 1'b1;
                @(posedge m_axis);
                rx_credit <= 1'b0;
                owed--;
            end
            default: fail_run("stimulus item has an unknown mode");
        endcase
        case (outcome)
            E_BEAT: begin
                wait_for("rx beat", SEL_BEAT, 1, limit);
                check_value("rx_beat_o.data", rx_q.pop_front(), b);
                owed++;
            end
            E_PERR: begin
                exp_perr++;
                wait_for("parity error pulse", SEL_PERR, exp_perr, limit);
            end
            E_OVF: begin
                exp_ovf++;
                wait_for("overflow pulse", SEL_OVF, exp_ovf, limit);
            end
            default: ;
        endcase
        repeat (d + 10) @(posedge m_axis);
        check_value("rx_beat_o extra beats", rx_q.size(), 0);
        check_value("rx_parity_err_o count", perr_cnt, exp_perr);
        check_value("rx_overflow_o count", ovf_cnt, exp_ovf);
        check_value("tx_credit_o count", txc_cnt, tx_sent);
        if (mode < M_HOLD) return_owed();
    endtask

    initial begin
        int          idx;
        logic [35:0] item;
        m_axis    = 1'b0;
        arst_n_i  = 1'b0;
        loop_sel  = 1'b0;
        drv_line  = 1'b1;
        rx_credit = 1'b0;
        parity    = uart_line_pkg::parity_none;
        clk_div   = 16'd8;
        tx_beat   = '0;
        void'($urandom(19));
        $readmemh("verif/axis_uart_stim.txt", stim_mem);
        repeat (2) @(posedge m_axis);
        arst_n_i <= 1'b1;
        @(posedge m_axis);
        for (idx = 0; idx < MAX_ITEMS; idx++) begin
            item = stim_mem[idx];
            if ($isunknown(item)) fail_run("stimulus file missing or item malformed");
            if (item[35:32] == M_END) break;
            run_item(item);
        end
        check_value("stimulus item count", (idx > 0), 1);
        if (txc_cnt == tx_sent && rx_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_run("credit or beat count mismatch at end of run");
        end
    end

endmodule

`default_nettype wire
